// File: exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// ======================================================================
// execute stage sizing
// ======================================================================

// operand and result width
`define EXE_XLEN        32

// rob tag, eight-entry reorder buffer
`define EXE_TAG_W       3

// physical destination register index
`define EXE_RD_W        7

// alu, mul, div, one result slot each
`define EXE_NUM_FU      3

// multiplier pipeline depth
`define EXE_MUL_STAGES  3

`endif

// File: exe_pkg.sv
`default_nettype none

`include "exe_defs.svh"

package exe_pkg;

    // unit select, value doubles as slot index
    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_MUL = 2'd1,
        FU_DIV = 2'd2
    } fu_sel_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        MUL, MULH, MULHU, DIV, DIVU, REM
    } exe_op_e;

    // remu shares the mulhu code, told apart by unit select
    localparam exe_op_e REMU = MULHU;

    typedef struct packed {
        fu_sel_e                fu_sel;
        exe_op_e                op;
        logic [`EXE_XLEN-1:0]   src_a;
        logic [`EXE_XLEN-1:0]   src_b;
        logic [`EXE_TAG_W-1:0]  tag;
        logic [`EXE_RD_W-1:0]   rd;
    } exe_req_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0]   data;
        logic [`EXE_TAG_W-1:0]  tag;
        logic [`EXE_RD_W-1:0]   rd;
    } exe_result_t;

endpackage

`default_nettype wire

// File: exe_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_defs.svh"

module exe_dispatch (
    input  logic                    i_valid,
    input  exe_pkg::exe_req_t       i_req,
    input  logic [`EXE_NUM_FU-1:0]  i_unit_ready,
    output logic                    o_ready,
    output logic [`EXE_NUM_FU-1:0]  o_unit_valid
);

    // one valid per unit, only the addressed one
    always_comb begin
        o_unit_valid = '0;
        for (int k = 0; k < `EXE_NUM_FU; k++) begin
            o_unit_valid[k] = i_valid && (i_req.fu_sel == k);
        end
    end

    // stage ready is the addressed unit's ready
    // an unknown select is never accepted
    assign o_ready = (i_req.fu_sel < `EXE_NUM_FU) ? i_unit_ready[i_req.fu_sel] : 1'b0;

    // a valid request always names one of the units
    always_comb begin
        if (i_valid) begin
            assert (i_req.fu_sel < `EXE_NUM_FU)
            else $error("valid request names no functional unit");
        end
    end

endmodule

`default_nettype wire

// File: exe_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_defs.svh"

module exe_alu (
    input  logic                    i_valid,
    input  exe_pkg::exe_req_t       i_req,
    input  logic                    i_slot_ready,
    output logic                    o_ready,
    output logic                    o_valid,
    output exe_pkg::exe_result_t    o_result
);

    import exe_pkg::*;

    localparam int SHAMT_W = $clog2(`EXE_XLEN);

    logic [SHAMT_W-1:0]     shamt;
    logic [`EXE_XLEN-1:0]   res;

    assign shamt = i_req.src_b[SHAMT_W-1:0];

    always_comb begin
        case (i_req.op)
            ADD:     res = i_req.src_a + i_req.src_b;
            SUB:     res = i_req.src_a - i_req.src_b;
            AND:     res = i_req.src_a & i_req.src_b;
            OR:      res = i_req.src_a | i_req.src_b;
            XOR:     res = i_req.src_a ^ i_req.src_b;
            SLL:     res = i_req.src_a << shamt;
            SRL:     res = i_req.src_a >> shamt;
            SRA:     res = $signed(i_req.src_a) >>> shamt;
            SLT:     res = {{(`EXE_XLEN-1){1'b0}}, $signed(i_req.src_a) < $signed(i_req.src_b)};
            SLTU:    res = {{(`EXE_XLEN-1){1'b0}}, i_req.src_a < i_req.src_b};
            default: res = '0;
        endcase
    end

    // no storage here, so ready is the slot's ready
    assign o_ready       = i_slot_ready;
    assign o_valid       = i_valid && i_slot_ready;
    assign o_result.data = res;
    assign o_result.tag  = i_req.tag;
    assign o_result.rd   = i_req.rd;

endmodule

`default_nettype wire

// File: exe_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_defs.svh"

module exe_mul (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  exe_pkg::exe_req_t       i_req,
    input  logic                    i_slot_ready,
    output logic                    o_ready,
    output logic                    o_valid,
    output exe_pkg::exe_result_t    o_result
);

    import exe_pkg::*;

    localparam int NS = `EXE_MUL_STAGES;

    typedef struct packed {
        logic [2*`EXE_XLEN-1:0] prod;
        logic                   hi;
        logic [`EXE_TAG_W-1:0]  tag;
        logic [`EXE_RD_W-1:0]   rd;
    } mul_stage_t;

    logic signed [`EXE_XLEN:0]      ext_a;
    logic signed [`EXE_XLEN:0]      ext_b;
    logic signed [2*`EXE_XLEN+1:0]  full;
    logic                           sext;
    mul_stage_t                     stg_in;
    mul_stage_t                     stg_q [NS];
    logic [NS-1:0]                  vld_q;

    // mulh is signed x signed, mulhu unsigned, mul takes the low half of either
    assign sext  = (i_req.op == MULH);
    assign ext_a = {sext & i_req.src_a[`EXE_XLEN-1], i_req.src_a};
    assign ext_b = {sext & i_req.src_b[`EXE_XLEN-1], i_req.src_b};
    assign full  = ext_a * ext_b;

    assign stg_in.prod = full[2*`EXE_XLEN-1:0];
    assign stg_in.hi   = (i_req.op == MULH) || (i_req.op == MULHU);
    assign stg_in.tag  = i_req.tag;
    assign stg_in.rd   = i_req.rd;

    // ======================================================================
    // pipeline, frozen as a whole while the slot holds
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else if (i_slot_ready) begin
            vld_q <= {vld_q[NS-2:0], i_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (i_slot_ready) begin
            stg_q[0] <= stg_in;
            for (int k = 1; k < NS; k++) begin
                stg_q[k] <= stg_q[k-1];
            end
        end
    end

    assign o_ready       = i_slot_ready;
    assign o_valid       = vld_q[NS-1] && i_slot_ready;
    assign o_result.data = stg_q[NS-1].hi ? stg_q[NS-1].prod[2*`EXE_XLEN-1:`EXE_XLEN]
                                          : stg_q[NS-1].prod[`EXE_XLEN-1:0];
    assign o_result.tag  = stg_q[NS-1].tag;
    assign o_result.rd   = stg_q[NS-1].rd;

endmodule

`default_nettype wire

// File: exe_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_defs.svh"

module exe_div (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  exe_pkg::exe_req_t       i_req,
    input  logic                    i_slot_ready,
    output logic                    o_ready,
    output logic                    o_valid,
    output exe_pkg::exe_result_t    o_result
);

    import exe_pkg::*;

    localparam int XL    = `EXE_XLEN;
    localparam int CNT_W = $clog2(XL) + 1;

    typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DONE} div_state_e;

    div_state_e         state_q;
    logic [CNT_W-1:0]   cnt_q;
    logic [XL-1:0]      quo_q;
    logic [XL-1:0]      rem_q;
    logic [XL-1:0]      dvs_q;
    logic               neg_quo_q;
    logic               neg_rem_q;
    logic               want_rem_q;
    logic               dvz_q;
    exe_result_t        res_q;
    logic               accept;
    logic               sgn;
    logic               a_neg;
    logic               b_neg;
    logic [XL:0]        shifted;
    logic [XL+1:0]      diff;

    assign accept = i_valid && o_ready;
    assign sgn    = (i_req.op == DIV) || (i_req.op == REM);
    assign a_neg  = sgn && i_req.src_a[XL-1];
    assign b_neg  = sgn && i_req.src_b[XL-1];

    // one restoring step: shift in next dividend bit, trial subtract
    assign shifted = {rem_q, quo_q[XL-1]};
    assign diff    = {1'b0, shifted} - {2'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_BUSY;
                        cnt_q   <= '0;
                    end
                end
                S_BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    // the cycle after the last step is the sign fix-up
                    if (cnt_q[CNT_W-1]) begin
                        state_q <= S_DONE;
                    end
                end
                default: begin
                    if (i_slot_ready) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // ======================================================================
    // datapath on magnitudes
    // ======================================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            quo_q      <= a_neg ? -i_req.src_a : i_req.src_a;
            rem_q      <= '0;
            dvs_q      <= b_neg ? -i_req.src_b : i_req.src_b;
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            want_rem_q <= (i_req.op == REM) || (i_req.op == REMU);
            dvz_q      <= (i_req.src_b == '0);
            res_q.tag  <= i_req.tag;
            res_q.rd   <= i_req.rd;
        end else if (state_q == S_BUSY && !cnt_q[CNT_W-1]) begin
            quo_q <= {quo_q[XL-2:0], !diff[XL+1]};
            rem_q <= diff[XL+1] ? shifted[XL-1:0] : diff[XL-1:0];
        end else if (state_q == S_BUSY) begin
            // remainder of a zero divisor already equals the dividend
            if (want_rem_q) begin
                res_q.data <= neg_rem_q ? -rem_q : rem_q;
            end else if (dvz_q) begin
                res_q.data <= '1;
            end else begin
                res_q.data <= neg_quo_q ? -quo_q : quo_q;
            end
        end
    end

    assign o_ready  = (state_q == S_IDLE);
    assign o_valid  = (state_q == S_DONE) && i_slot_ready;
    assign o_result = res_q;

    // a request that meets a busy divider waits unchanged until taken
    a_req_held_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        i_valid && !o_ready |=> !i_valid || $stable(i_req)
    ) else $error("request changed while waiting on the busy divider");

endmodule

`default_nettype wire

// File: exe_result_slot.sv
`timescale 1ns/1ps
`default_nettype none

module exe_result_slot (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  exe_pkg::exe_result_t    i_result,
    input  logic                    i_grant,
    output logic                    o_unit_ready,
    output logic                    o_valid,
    output exe_pkg::exe_result_t    o_result
);

    import exe_pkg::*;

    logic           bypass_q;
    exe_result_t    hold_q;

    // bypass -> hold on a lost arbitration, hold -> bypass on grant
    always_ff @(posedge clk) begin
        if (rst) begin
            bypass_q <= 1'b1;
        end else if (bypass_q) begin
            if (i_valid && !i_grant) begin
                bypass_q <= 1'b0;
            end
        end else if (i_grant) begin
            bypass_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bypass_q && i_valid && !i_grant) begin
            hold_q <= i_result;
        end
    end

    assign o_unit_ready = bypass_q;
    assign o_valid      = bypass_q ? i_valid : 1'b1;
    assign o_result     = bypass_q ? i_result : hold_q;

    // the unit must stall while the slot holds
    a_no_input_in_hold: assert property (
        @(posedge clk) disable iff (rst)
        !bypass_q |-> !i_valid
    ) else $error("unit result arrived while slot was holding");

endmodule

`default_nettype wire

// File: exe_wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_defs.svh"

module exe_wb_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`EXE_NUM_FU-1:0]  i_slot_valid,
    input  exe_pkg::exe_result_t    i_slot_result [`EXE_NUM_FU],
    output logic [`EXE_NUM_FU-1:0]  o_grant,
    output logic                    o_wb_valid,
    output exe_pkg::exe_result_t    o_wb_result
);

    import exe_pkg::*;

    exe_result_t            win_result;
    logic [`EXE_NUM_FU-1:0] lost;

    // ======================================================================
    // fixed priority, higher slot index wins (div > mul > alu)
    // ======================================================================
    always_comb begin
        o_grant    = '0;
        win_result = i_slot_result[0];
        for (int k = 0; k < `EXE_NUM_FU; k++) begin
            if (i_slot_valid[k]) begin
                o_grant    = '0;
                o_grant[k] = 1'b1;
                win_result = i_slot_result[k];
            end
        end
    end

    // writeback register, never stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= |o_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (|o_grant) begin
            o_wb_result <= win_result;
        end
    end

    // slots that had a result but lost this cycle
    assign lost = i_slot_valid & ~o_grant;

    // a losing slot still offers its result on the next cycle
    a_loser_kept: assert property (
        @(posedge clk) disable iff (rst)
        (|lost) |=> ((i_slot_valid & $past(lost)) == $past(lost))
    ) else $error("slot dropped a result that lost arbitration");

endmodule

`default_nettype wire

// File: exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_defs.svh"

module exe_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  exe_pkg::exe_req_t       i_req,
    output logic                    o_ready,
    output logic                    o_wb_valid,
    output exe_pkg::exe_result_t    o_wb_result
);

    import exe_pkg::*;

    logic [`EXE_NUM_FU-1:0] unit_valid;
    logic [`EXE_NUM_FU-1:0] unit_ready;
    logic [`EXE_NUM_FU-1:0] res_valid;
    exe_result_t            unit_res [`EXE_NUM_FU];
    logic [`EXE_NUM_FU-1:0] slot_ready;
    logic [`EXE_NUM_FU-1:0] slot_valid;
    exe_result_t            slot_res [`EXE_NUM_FU];
    logic [`EXE_NUM_FU-1:0] grant;

    exe_dispatch dispatch_i (
        .i_valid      (i_valid),
        .i_req        (i_req),
        .i_unit_ready (unit_ready),
        .o_ready      (o_ready),
        .o_unit_valid (unit_valid)
    );

    // ======================================================================
    // functional units
    // ======================================================================
    exe_alu alu_i (
        .i_valid      (unit_valid[FU_ALU]),
        .i_req        (i_req),
        .i_slot_ready (slot_ready[FU_ALU]),
        .o_ready      (unit_ready[FU_ALU]),
        .o_valid      (res_valid[FU_ALU]),
        .o_result     (unit_res[FU_ALU])
    );

    exe_mul mul_i (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (unit_valid[FU_MUL]),
        .i_req        (i_req),
        .i_slot_ready (slot_ready[FU_MUL]),
        .o_ready      (unit_ready[FU_MUL]),
        .o_valid      (res_valid[FU_MUL]),
        .o_result     (unit_res[FU_MUL])
    );

    exe_div div_i (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (unit_valid[FU_DIV]),
        .i_req        (i_req),
        .i_slot_ready (slot_ready[FU_DIV]),
        .o_ready      (unit_ready[FU_DIV]),
        .o_valid      (res_valid[FU_DIV]),
        .o_result     (unit_res[FU_DIV])
    );

    // one result slot per unit
    for (genvar g = 0; g < `EXE_NUM_FU; g++) begin : g_slot
        exe_result_slot slot_i (
            .clk          (clk),
            .rst          (rst),
            .i_valid      (res_valid[g]),
            .i_result     (unit_res[g]),
            .i_grant      (grant[g]),
            .o_unit_ready (slot_ready[g]),
            .o_valid      (slot_valid[g]),
            .o_result     (slot_res[g])
        );
    end

    exe_wb_arbiter wb_arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .i_slot_valid  (slot_valid),
        .i_slot_result (slot_res),
        .o_grant       (grant),
        .o_wb_valid    (o_wb_valid),
        .o_wb_result   (o_wb_result)
    );

endmodule

`default_nettype wire

// File: exe_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_defs.svh"

module exe_stage_tb;

    import exe_pkg::*;

    localparam int  MAX_VEC   = 64;
    localparam int  VEC_WORDS = 7;
    localparam int  NTAG      = 1 << `EXE_TAG_W;
    localparam time DRIVE_DLY = 5;

    logic                   clk;
    logic                   rst;
    logic                   req_valid;
    exe_req_t               req;
    logic                   ready;
    logic                   wb_valid;
    exe_result_t            wb_result;

    // unit, op, a, b, tag, rd, expected data per vector
    logic [31:0]            vec_mem [MAX_VEC*VEC_WORDS];
    int                     num_vec;
    logic [`EXE_XLEN-1:0]   cur_exp;

    // scoreboard indexed by rob tag
    logic                   pending [NTAG];
    logic [`EXE_XLEN-1:0]   exp_data [NTAG];
    logic [`EXE_RD_W-1:0]   exp_rd [NTAG];
    logic                   is_mul [NTAG];
    int                     outstanding;
    int                     mul_inflight;
    int                     max_mul_inflight;
    logic                   accepted_any;

    int                     mismatch_cnt = 0;
    int                     other_cnt = 0;
    int                     cycle_cnt = 0;
    int                     timeout_limit = 0;
    integer                 seed;
    int                     gap;
    logic                   this_mul;
    logic                   prev_mul;

    exe_stage dut_i (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (req_valid),
        .i_req       (req),
        .o_ready     (ready),
        .o_wb_valid  (wb_valid),
        .o_wb_result (wb_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    endtask

    // hold the request until the stage takes it
    task automatic issue_request(input int base);
        logic took;
        req.fu_sel = fu_sel_e'(vec_mem[base][1:0]);
        req.op     = exe_op_e'(vec_mem[base+1][3:0]);
        req.src_a  = vec_mem[base+2];
        req.src_b  = vec_mem[base+3];
        req.tag    = vec_mem[base+4][`EXE_TAG_W-1:0];
        req.rd     = vec_mem[base+5][`EXE_RD_W-1:0];
        cur_exp    = vec_mem[base+6];
        // a tag is reused only once its earlier result is back
        while (pending[req.tag]) begin
            step_cycle();
        end
        req_valid = 1'b1;
        took      = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = ready;
            step_cycle();
        end
        req_valid = 1'b0;
    endtask

    // ======================================================================
    // writeback checks and handshake tracking, sampled mid-cycle
    // ======================================================================
    always @(negedge clk) begin
        if (rst) begin
            for (int t = 0; t < NTAG; t++) begin
                pending[t] = 1'b0;
            end
            outstanding      = 0;
            mul_inflight     = 0;
            max_mul_inflight = 0;
            accepted_any     = 1'b0;
        end else begin
            if (wb_valid) begin
                assert (accepted_any)
                else begin
                    other_cnt++;
                    $display("time %0t: writeback valid before any request", $time);
                end
                assert (pending[wb_result.tag])
                else begin
                    other_cnt++;
                    $display("time %0t: tag %0d written back but not outstanding",
                             $time, wb_result.tag);
                end
                if (pending[wb_result.tag]) begin
                    assert (wb_result.data == exp_data[wb_result.tag])
                    else begin
                        mismatch_cnt++;
                        $display("MISMATCH time %0t o_wb_result.data tag %0d exp %h got %h",
                                 $time, wb_result.tag, exp_data[wb_result.tag],
                                 wb_result.data);
                    end
                    assert (wb_result.rd == exp_rd[wb_result.tag])
                    else begin
                        mismatch_cnt++;
                        $display("MISMATCH time %0t o_wb_result.rd tag %0d exp %h got %h",
                                 $time, wb_result.tag, exp_rd[wb_result.tag], wb_result.rd);
                    end
                    pending[wb_result.tag] = 1'b0;
                    outstanding--;
                    if (is_mul[wb_result.tag]) begin
                        mul_inflight--;
                    end
                end
            end
            if (req_valid && ready) begin
                assert (!pending[req.tag])
                else begin
                    other_cnt++;
                    $display("time %0t: tag %0d issued while still outstanding",
                             $time, req.tag);
                end
                pending[req.tag]  = 1'b1;
                exp_data[req.tag] = cur_exp;
                exp_rd[req.tag]   = req.rd;
                is_mul[req.tag]   = (req.fu_sel == FU_MUL);
                accepted_any      = 1'b1;
                outstanding++;
                if (req.fu_sel == FU_MUL) begin
                    mul_inflight++;
                    if (mul_inflight > max_mul_inflight) begin
                        max_mul_inflight = mul_inflight;
                    end
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles", cycle_cnt);
            for (int t = 0; t < NTAG; t++) begin
                if (pending[t]) begin
                    $display("tag %0d never returned", t);
                end
            end
            report_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        cur_exp   = '0;
        seed      = 32'h8956;
        prev_mul  = 1'b0;
        for (int k = 0; k < MAX_VEC * VEC_WORDS; k++) begin
            vec_mem[k] = {16'hdead, k[15:0]};
        end
        $readmemh("exe_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[VEC_WORDS*num_vec][31:16] == 16'h0) begin
            num_vec++;
        end
        timeout_limit = 50 * num_vec + 200;
        assert (num_vec > 0)
        else begin
            other_cnt++;
            $display("no vectors were read from exe_vectors.txt");
        end

        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        // idle cycles, writeback must stay quiet
        repeat (3) step_cycle();

        for (int n = 0; n < num_vec; n++) begin
            this_mul = (vec_mem[VEC_WORDS*n][1:0] == FU_MUL);
            // consecutive multiplies go out every cycle
            if (n > 0 && !(this_mul && prev_mul)) begin
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) step_cycle();
            end
            issue_request(VEC_WORDS * n);
            prev_mul = this_mul;
        end

        while (outstanding != 0) begin
            step_cycle();
        end
        repeat (4) step_cycle();

        assert (max_mul_inflight >= `EXE_MUL_STAGES)
        else begin
            other_cnt++;
            $display("multiplier never had %0d requests in flight, max was %0d",
                     `EXE_MUL_STAGES, max_mul_inflight);
        end

        report_counts();
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exe_vectors.txt
// unit(0 alu 1 mul 2 div) op a b tag rd expected_data, all hex
// op codes: add 0 sub 1 sra 7 slt 8 sltu 9 mul a mulh b mulhu c div d divu e rem f remu c
0 0 00000005 00000007 0 01 0000000c
0 1 00000003 00000005 1 02 fffffffe
0 7 80000000 00000004 2 03 f8000000
0 8 ffffffff 00000001 3 04 00000001
0 9 ffffffff 00000001 4 05 00000000
1 a fffffffd 00000007 0 10 ffffffeb
1 b fffffffd 00000007 1 11 ffffffff
1 c 80000000 00000004 2 12 00000002
1 b 80000000 80000000 3 13 40000000
2 d 80000000 ffffffff 5 20 80000000
1 a 00001234 00010000 6 21 12340000
1 a 0000ffff 0000ffff 7 22 fffe0001
2 d 00000064 00000000 4 23 ffffffff
2 f fffffff9 00000000 0 24 fffffff9
2 e 00000064 00000007 1 25 0000000e
2 f fffffff9 00000002 2 26 ffffffff
2 c 00000064 00000007 3 27 00000002

// File: project.f
+incdir+.
exe_pkg.sv
exe_dispatch.sv
exe_alu.sv
exe_mul.sv
exe_div.sv
exe_result_slot.sv
exe_wb_arbiter.sv
exe_stage.sv
exe_stage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exe_stage_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
